// ==== posit_pkg.sv ====
`default_nettype none

package posit_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // posit number format
  ////////////////////////////////////////////////////////////////////////////

  localparam int N          = 16;                     // posit width
  localparam int ES         = 1;                      // exponent field size
  localparam int TE_BITS    = $clog2(N) + ES + 2;     // room for te1 - te2 - 1
  localparam int MANT_SIZE  = 12;                     // mantissa incl. hidden one
  localparam int RECIP_FRAC = 2 * MANT_SIZE;          // reciprocal fraction bits

  typedef logic signed [TE_BITS-1:0] exponent_t;      // total exponent

  // one decoded operand as it travels down the operand path
  typedef struct packed {
    logic                 sign;
    exponent_t            te;
    logic [MANT_SIZE-1:0] mant;                       // 1.f, hidden one at the top
  } operand_t;

endpackage

`default_nettype wire

// ==== div_pkg.sv ====
`default_nettype none

package div_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // divider pipeline timing
  ////////////////////////////////////////////////////////////////////////////

  localparam int NR_ITERS_DEFAULT = 2;                // newton-raphson refinements
  localparam int SEED_LAT         = 1;                // linear seed stage
  localparam int NR_LAT           = 2;                // per refinement stage
  localparam int NORM_LAT         = 1;                // multiply and normalize

  // input-to-output latency for a given refinement count
  function automatic int div_latency(input int nr_iters);
    return SEED_LAT + nr_iters * NR_LAT + NORM_LAT;
  endfunction

  localparam int DIV_LAT_DEFAULT = div_latency(NR_ITERS_DEFAULT);

endpackage

`default_nettype wire

// ==== div_op_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface div_op_if #(
  parameter int MANT_SIZE = posit_pkg::MANT_SIZE
) ();
  import posit_pkg::*;

  logic                 valid;                        // bundle holds a live operand
  logic                 sign;                         // result sign
  exponent_t            te;                           // te1 - te2, not yet adjusted
  logic [MANT_SIZE-1:0] mant;                         // dividend mantissa

  modport src (
    output valid,
    output sign,
    output te,
    output mant
  );

  modport snk (
    input valid,
    input sign,
    input te,
    input mant
  );

endinterface

`default_nettype wire

// ==== pipe_delay.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_delay #(
  parameter int  DEPTH     = 1,
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  if (DEPTH == 0) begin : g_pass
    assign valid_o = valid_i;                         // zero depth is a plain wire
    assign data_o  = data_i;
  end else begin : g_regs
    logic     [DEPTH-1:0] valid_q;
    payload_t             data_q [DEPTH];

    always_ff @(posedge clk_i) begin
      if (rst) begin
        valid_q <= '0;
      end else begin
        valid_q[0] <= valid_i;
        for (int i = 1; i < DEPTH; i++) begin
          valid_q[i] <= valid_q[i-1];
        end
      end
    end

    always_ff @(posedge clk_i) begin
      data_q[0] <= data_i;                            // payload shifts without reset
      for (int i = 1; i < DEPTH; i++) begin
        data_q[i] <= data_q[i-1];
      end
    end

    assign valid_o = valid_q[DEPTH-1];
    assign data_o  = data_q[DEPTH-1];
  end

endmodule

`default_nettype wire

// ==== recip_seed.sv ====
`timescale 1ns/10ps
`default_nettype none

module recip_seed #(
  parameter int MANT_SIZE = posit_pkg::MANT_SIZE
) (
  input  logic                          clk_i,
  input  logic                          rst,
  input  logic                          valid_i,
  input  logic [MANT_SIZE-1:0]          mant_i,
  output logic                          valid_o,
  output logic [posit_pkg::RECIP_FRAC:0] recip_o,
  output logic [MANT_SIZE-1:0]          mant_o
);
  import posit_pkg::*;

  localparam int RW = RECIP_FRAC + 1;                 // one integer bit, x0 can be 1.0

  logic [RW-1:0] three_minus_d;
  logic [RW-1:0] seed;

  ////////////////////////////////////////////////////////////////////////////
  // linear seed x0 = (3 - d) / 2
  ////////////////////////////////////////////////////////////////////////////

  // d is 1.f with MANT_SIZE-1 fraction bits, so 3 - d lies in (1, 2]
  assign three_minus_d = (RW'(3) << (MANT_SIZE - 1)) - RW'(mant_i);

  // halving and widening to RECIP_FRAC fraction bits is one left shift, exact
  assign seed = three_minus_d << (RECIP_FRAC - MANT_SIZE);

  always_ff @(posedge clk_i) begin
    if (rst) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    recip_o <= seed;
    mant_o  <= mant_i;                                // divisor rides along for the nr stages
  end

endmodule

`default_nettype wire

// ==== newton_raphson.sv ====
`timescale 1ns/10ps
`default_nettype none

module newton_raphson #(
  parameter int MANT_SIZE = posit_pkg::MANT_SIZE
) (
  input  logic                          clk_i,
  input  logic                          rst,
  input  logic                          valid_i,
  input  logic [MANT_SIZE-1:0]          mant_i,
  input  logic [posit_pkg::RECIP_FRAC:0] recip_i,
  output logic                          valid_o,
  output logic [posit_pkg::RECIP_FRAC:0] recip_o,
  output logic [MANT_SIZE-1:0]          mant_o
);
  import posit_pkg::*;

  localparam int RW = RECIP_FRAC + 1;                 // x is at most 1.0
  localparam int PW = MANT_SIZE + RW;                 // d * x before truncation

  typedef logic [MANT_SIZE+RW-1:0] carry_t;           // {divisor, x}

  logic [PW-1:0]     dx_full;
  logic [RW-1:0]     dx_q;
  carry_t            carry_q;
  logic              valid_q;
  logic [MANT_SIZE-1:0] mant_q;
  logic [RW-1:0]     x_q;
  logic [RW:0]       two_minus_dx;
  logic [2*RW:0]     x_next_full;
  logic [RW-1:0]     x_next;

  ////////////////////////////////////////////////////////////////////////////
  // cycle 1: d * x truncated to RECIP_FRAC fraction bits
  ////////////////////////////////////////////////////////////////////////////

  assign dx_full = PW'(mant_i) * PW'(recip_i);        // MANT_SIZE-1 + RECIP_FRAC fraction bits

  always_ff @(posedge clk_i) begin
    dx_q <= dx_full[MANT_SIZE-1 +: RW];               // d * x stays below 2
  end

  pipe_delay #(
    .DEPTH     (1),
    .payload_t (carry_t)
  ) u_carry (
    .clk_i   (clk_i),
    .rst     (rst),
    .valid_i (valid_i),
    .data_i  ({mant_i, recip_i}),
    .valid_o (valid_q),
    .data_o  (carry_q)
  );

  assign {mant_q, x_q} = carry_q;

  ////////////////////////////////////////////////////////////////////////////
  // cycle 2: x' = x * (2 - d * x)
  ////////////////////////////////////////////////////////////////////////////

  assign two_minus_dx = ((RW + 1)'(2) << RECIP_FRAC) - (RW + 1)'(dx_q);
  assign x_next_full  = (2 * RW + 1)'(x_q) * (2 * RW + 1)'(two_minus_dx);
  assign x_next       = x_next_full[RECIP_FRAC +: RW];   // truncate, x' never exceeds 1/d

  always_ff @(posedge clk_i) begin
    if (rst) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    recip_o <= x_next;
    mant_o  <= mant_q;
  end

endmodule

`default_nettype wire

// ==== recip_path.sv ====
`timescale 1ns/10ps
`default_nettype none

module recip_path #(
  parameter int MANT_SIZE = posit_pkg::MANT_SIZE,
  parameter int NR_ITERS  = div_pkg::NR_ITERS_DEFAULT
) (
  input  logic                          clk_i,
  input  logic                          rst,
  input  logic                          valid_i,
  input  logic [MANT_SIZE-1:0]          mant2_i,
  output logic                          valid_o,
  output logic [posit_pkg::RECIP_FRAC:0] recip_o
);
  import posit_pkg::*;

  // index 0 is the seed, index i+1 the output of refinement i
  logic [NR_ITERS:0]    valid_c;
  logic [RECIP_FRAC:0]  recip_c [NR_ITERS+1];
  logic [MANT_SIZE-1:0] mant_c  [NR_ITERS+1];

  recip_seed #(
    .MANT_SIZE (MANT_SIZE)
  ) u_seed (
    .clk_i   (clk_i),
    .rst     (rst),
    .valid_i (valid_i),
    .mant_i  (mant2_i),
    .valid_o (valid_c[0]),
    .recip_o (recip_c[0]),
    .mant_o  (mant_c[0])
  );

  for (genvar i = 0; i < NR_ITERS; i++) begin : g_nr
    newton_raphson #(
      .MANT_SIZE (MANT_SIZE)
    ) u_nr (
      .clk_i   (clk_i),
      .rst     (rst),
      .valid_i (valid_c[i]),
      .mant_i  (mant_c[i]),                           // divisor follows its own estimate
      .recip_i (recip_c[i]),
      .valid_o (valid_c[i+1]),
      .recip_o (recip_c[i+1]),
      .mant_o  (mant_c[i+1])
    );
  end

  assign valid_o = valid_c[NR_ITERS];
  assign recip_o = recip_c[NR_ITERS];

endmodule

`default_nettype wire

// ==== operand_path.sv ====
`timescale 1ns/10ps
`default_nettype none

module operand_path #(
  parameter int MANT_SIZE = posit_pkg::MANT_SIZE,
  parameter int NR_ITERS  = div_pkg::NR_ITERS_DEFAULT
) (
  input  logic                 clk_i,
  input  logic                 rst,
  input  logic                 valid_i,
  input  logic                 sign1_i,
  input  logic                 sign2_i,
  input  posit_pkg::exponent_t te1_i,
  input  posit_pkg::exponent_t te2_i,
  input  logic [MANT_SIZE-1:0] mant1_i,
  div_op_if.src                op_o
);
  import posit_pkg::*;
  import div_pkg::*;

  localparam int DEPTH = SEED_LAT + NR_ITERS * NR_LAT;   // matches recip_path

  operand_t op_in;
  operand_t op_out;
  logic     valid_out;

  assign op_in.sign = sign1_i ^ sign2_i;
  assign op_in.te   = te1_i - te2_i;                  // normalize may still take one off
  assign op_in.mant = mant1_i;

  pipe_delay #(
    .DEPTH     (DEPTH),
    .payload_t (operand_t)
  ) u_delay (
    .clk_i   (clk_i),
    .rst     (rst),
    .valid_i (valid_i),
    .data_i  (op_in),
    .valid_o (valid_out),
    .data_o  (op_out)
  );

  assign op_o.valid = valid_out;
  assign op_o.sign  = op_out.sign;
  assign op_o.te    = op_out.te;
  assign op_o.mant  = op_out.mant;

endmodule

`default_nettype wire

// ==== div_normalize.sv ====
`timescale 1ns/10ps
`default_nettype none

module div_normalize #(
  parameter int MANT_SIZE = posit_pkg::MANT_SIZE
) (
  input  logic                          clk_i,
  input  logic                          rst,
  div_op_if.snk                         op_i,
  input  logic                          recip_valid_i,
  input  logic [posit_pkg::RECIP_FRAC:0] recip_i,
  output logic                          valid_o,
  output logic                          sign_o,
  output posit_pkg::exponent_t          te_o,
  output logic [MANT_SIZE-1:0]          mant_o
);
  import posit_pkg::*;

  localparam int RW    = RECIP_FRAC + 1;
  localparam int QW    = MANT_SIZE + RW;              // full quotient product
  localparam int Q_ONE = MANT_SIZE - 1 + RECIP_FRAC;  // bit weight of 1.0 in q

  logic [QW-1:0] q;
  logic [QW-1:0] q_norm;
  logic          below_one;
  exponent_t     te_adj;

  ////////////////////////////////////////////////////////////////////////////
  // q = mant1 * (1 / mant2), then bring q into [1, 2)
  ////////////////////////////////////////////////////////////////////////////

  assign q = QW'(op_i.mant) * QW'(recip_i);           // q lies in (0.5, 2)

  assign below_one = ~q[Q_ONE];
  assign q_norm    = below_one ? (q << 1) : q;
  assign te_adj    = below_one ? (op_i.te - exponent_t'(1)) : op_i.te;

  always_ff @(posedge clk_i) begin
    if (rst) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= op_i.valid & recip_valid_i;          // both paths are aligned by construction
    end
  end

  always_ff @(posedge clk_i) begin
    sign_o <= op_i.sign;
    te_o   <= te_adj;
    mant_o <= q_norm[Q_ONE -: MANT_SIZE];             // truncated, hidden one at the top
  end

endmodule

`default_nettype wire

// ==== div_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module div_top #(
  parameter int MANT_SIZE = posit_pkg::MANT_SIZE,
  parameter int NR_ITERS  = div_pkg::NR_ITERS_DEFAULT
) (
  input  logic                 clk_i,
  input  logic                 rst,
  input  logic                 valid_i,
  input  logic                 sign1_i,
  input  logic                 sign2_i,
  input  posit_pkg::exponent_t te1_i,
  input  posit_pkg::exponent_t te2_i,
  input  logic [MANT_SIZE-1:0] mant1_i,
  input  logic [MANT_SIZE-1:0] mant2_i,
  output logic                 valid_o,
  output logic                 sign_o,
  output posit_pkg::exponent_t te_o,
  output logic [MANT_SIZE-1:0] mant_o
);
  import div_pkg::*;

  // input to output latency in cycles, for bound checkers
  localparam int LATENCY = div_latency(NR_ITERS);

  logic                          recip_valid;
  logic [posit_pkg::RECIP_FRAC:0] recip;

  div_op_if #(.MANT_SIZE(MANT_SIZE)) op_if ();

  ////////////////////////////////////////////////////////////////////////////
  // two parallel paths meeting in the normalizer
  ////////////////////////////////////////////////////////////////////////////

  recip_path #(
    .MANT_SIZE (MANT_SIZE),
    .NR_ITERS  (NR_ITERS)
  ) u_recip_path (
    .clk_i   (clk_i),
    .rst     (rst),
    .valid_i (valid_i),
    .mant2_i (mant2_i),
    .valid_o (recip_valid),
    .recip_o (recip)
  );

  operand_path #(
    .MANT_SIZE (MANT_SIZE),
    .NR_ITERS  (NR_ITERS)
  ) u_operand_path (
    .clk_i   (clk_i),
    .rst     (rst),
    .valid_i (valid_i),
    .sign1_i (sign1_i),
    .sign2_i (sign2_i),
    .te1_i   (te1_i),
    .te2_i   (te2_i),
    .mant1_i (mant1_i),
    .op_o    (op_if.src)
  );

  div_normalize #(
    .MANT_SIZE (MANT_SIZE)
  ) u_normalize (
    .clk_i         (clk_i),
    .rst           (rst),
    .op_i          (op_if.snk),
    .recip_valid_i (recip_valid),
    .recip_i       (recip),
    .valid_o       (valid_o),
    .sign_o        (sign_o),
    .te_o          (te_o),
    .mant_o        (mant_o)
  );

endmodule

`default_nettype wire

// ==== div_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module div_props #(
  parameter int MANT_SIZE = posit_pkg::MANT_SIZE,
  parameter int LATENCY   = div_pkg::DIV_LAT_DEFAULT
) (
  input logic                 clk_i,
  input logic                 rst,
  input logic                 valid_i,
  input logic                 valid_o,
  input logic                 sign_o,
  input posit_pkg::exponent_t te_o,
  input logic [MANT_SIZE-1:0] mant_o
);

  int warm;                                           // cycles since reset release, saturates

  always_ff @(posedge clk_i) begin
    if (rst) begin
      warm <= 0;
    end else if (warm < LATENCY) begin
      warm <= warm + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output handshake and result shape
  ////////////////////////////////////////////////////////////////////////////

  // synchronous reset clears every valid bit on the same edge
  a_reset_clears_valid: assert property (@(posedge clk_i) rst |=> !valid_o)
    else $error("valid_o high in the cycle after a reset cycle");

  a_valid_latency: assert property (@(posedge clk_i) disable iff (rst)
    (warm == LATENCY) |-> (valid_o == $past(valid_i, LATENCY)))
    else $error("valid_o does not follow valid_i by the pipeline latency");

  a_mant_normalized: assert property (@(posedge clk_i) disable iff (rst)
    valid_o |-> mant_o[MANT_SIZE-1])
    else $error("mant_o lacks its hidden one while valid_o is high");

  a_outputs_known: assert property (@(posedge clk_i) disable iff (rst)
    valid_o |-> !$isunknown({sign_o, te_o, mant_o}))
    else $error("unknown bits on the result while valid_o is high");

endmodule

`default_nettype wire

// ==== tb_div_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_div_top;
  import posit_pkg::*;
  import div_pkg::*;

  localparam int MS         = MANT_SIZE;
  localparam int RF         = RECIP_FRAC;
  localparam int ITERS      = NR_ITERS_DEFAULT;
  localparam int LAT        = DIV_LAT_DEFAULT;
  localparam int TE_MAX     = (N - 2) * (1 << ES);    // largest te of an N-bit posit
  localparam int N_DIRECT   = 32;                     // upper bound on directed operands
  localparam int N_RANDOM   = 300;
  localparam int N_GAP      = 120;
  localparam int MAX_CYCLES = 3 + N_DIRECT + N_RANDOM + N_GAP + 2 * LAT + 50;

  typedef logic [MS-1:0] mant_t;

  typedef struct packed {
    logic      sign;
    exponent_t te;
    mant_t     mant;
  } result_t;

  localparam mant_t ONE      = {1'b1, {(MS - 1){1'b0}}};
  localparam mant_t ONE_HALF = ONE | (ONE >> 1);      // 1.5

  logic      clk_i = 1'b0;
  logic      rst;
  logic      valid_i;
  logic      sign1_i;
  logic      sign2_i;
  exponent_t te1_i;
  exponent_t te2_i;
  mant_t     mant1_i;
  mant_t     mant2_i;
  logic      valid_o;
  logic      sign_o;
  exponent_t te_o;
  mant_t     mant_o;

  logic [31:0]    lfsr_state = 32'h5536_706f;
  result_t        exp_q [$];
  string          name_q [$];
  logic [LAT-1:0] vhist = '0;                         // valid_i as sampled on recent edges
  int             cycles = 0;

  always #2 clk_i = ~clk_i;

  div_top #(
    .MANT_SIZE (MS),
    .NR_ITERS  (ITERS)
  ) div_top_i (
    .clk_i   (clk_i),
    .rst     (rst),
    .valid_i (valid_i),
    .sign1_i (sign1_i),
    .sign2_i (sign2_i),
    .te1_i   (te1_i),
    .te2_i   (te2_i),
    .mant1_i (mant1_i),
    .mant2_i (mant2_i),
    .valid_o (valid_o),
    .sign_o  (sign_o),
    .te_o    (te_o),
    .mant_o  (mant_o)
  );

  bind div_top div_props #(
    .MANT_SIZE (MANT_SIZE),
    .LATENCY   (LATENCY)
  ) u_props (
    .clk_i   (clk_i),
    .rst     (rst),
    .valid_i (valid_i),
    .valid_o (valid_o),
    .sign_o  (sign_o),
    .te_o    (te_o),
    .mant_o  (mant_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;                // taps 32, 22, 2, 1
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  function automatic logic rand_bit();
    logic [31:0] b;
    b = rand_bits(1);
    return b[0];
  endfunction

  function automatic mant_t rand_mant();
    logic [31:0] b;
    b = rand_bits(MS - 1);
    return {1'b1, b[MS-2:0]};                         // hidden one always set
  endfunction

  function automatic exponent_t rand_te();
    logic [31:0] b;
    b = rand_bits(6);
    return exponent_t'(int'(b % (2 * TE_MAX + 1)) - TE_MAX);
  endfunction

  function automatic result_t div_model(input logic s1, input logic s2,
                                        input exponent_t t1, input exponent_t t2,
                                        input mant_t m1, input mant_t m2);
    longint unsigned x;
    longint unsigned dx;
    longint unsigned two_minus;
    longint unsigned q;
    result_t         r;
    // seed (3 - d) / 2, d has MS-1 fraction bits and x has RF
    x = (64'(3) << (MS - 1)) - 64'(m2);
    x = x << (RF - MS);
    for (int i = 0; i < ITERS; i++) begin
      dx        = (64'(m2) * x) >> (MS - 1);
      two_minus = (64'(2) << RF) - dx;
      x         = (x * two_minus) >> RF;
    end
    q      = 64'(m1) * x;                             // MS-1+RF fraction bits
    r.sign = s1 ^ s2;
    r.te   = t1 - t2;
    if (q < (64'(1) << (MS - 1 + RF))) begin
      q    = q << 1;
      r.te = r.te - exponent_t'(1);
    end
    r.mant = MS'(q >> RF);
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic end_with_failure();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected %0b, actual %0b", name, expected, actual);
      end_with_failure();
    end
  endtask

  task automatic check_te(input string name, input exponent_t expected,
                          input exponent_t actual);
    if (actual !== expected) begin
      $display("FAIL %s te: expected %0d, actual %0d", name, expected, actual);
      end_with_failure();
    end
  endtask

  task automatic check_mant(input string name, input mant_t expected, input mant_t actual);
    if (actual !== expected) begin
      $display("FAIL %s mant: expected %h, actual %h", name, expected, actual);
      end_with_failure();
    end
  endtask

  // model against the exact quotient, truncated in the model's own binade
  task automatic check_ulp(input string name, input mant_t m1, input mant_t m2,
                           input result_t r, input exponent_t te_diff);
    longint unsigned exact;
    longint unsigned diff;
    if (r.te != te_diff) begin
      exact = (64'(m1) << MS) / 64'(m2);              // q below one keeps one more bit
    end else begin
      exact = (64'(m1) << (MS - 1)) / 64'(m2);
    end
    diff = (exact > 64'(r.mant)) ? exact - 64'(r.mant) : 64'(r.mant) - exact;
    if (diff > 2) begin
      $display("FAIL %s ulp: expected %0h within 2 ulp, actual %0h", name, exact, r.mant);
      end_with_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic send(input string name, input logic s1, input logic s2,
                      input exponent_t t1, input exponent_t t2,
                      input mant_t m1, input mant_t m2, output result_t model);
    @(negedge clk_i);
    valid_i = 1'b1;
    sign1_i = s1;
    sign2_i = s2;
    te1_i   = t1;
    te2_i   = t2;
    mant1_i = m1;
    mant2_i = m2;
    model   = div_model(s1, s2, t1, t2, m1, m2);
    exp_q.push_back(model);
    name_q.push_back(name);
  endtask

  task automatic send_random(input string name);
    logic      s1;
    logic      s2;
    exponent_t t1;
    exponent_t t2;
    mant_t     m1;
    mant_t     m2;
    result_t   r;
    s1 = rand_bit();
    s2 = rand_bit();
    t1 = rand_te();
    t2 = rand_te();
    m1 = rand_mant();
    m2 = rand_mant();
    send(name, s1, s2, t1, t2, m1, m2, r);
    check_ulp(name, m1, m2, r, t1 - t2);
  endtask

  task automatic idle();
    @(negedge clk_i);
    valid_i = 1'b0;
  endtask

  initial begin : stimulus
    result_t   r;
    mant_t     m;
    exponent_t t1;
    exponent_t t2;
    logic [1:0] sg;
    valid_i = 1'b0;
    sign1_i = 1'b0;
    sign2_i = 1'b0;
    te1_i   = '0;
    te2_i   = '0;
    mant1_i = ONE;
    mant2_i = ONE;
    rst     = 1'b1;
    repeat (3) @(negedge clk_i);
    rst = 1'b0;
    idle();

    // a divisor of 1.0 makes the seed exact
    for (int i = 0; i < 4; i++) begin
      m  = rand_mant();
      t1 = rand_te();
      t2 = rand_te();
      send("div by one", 1'b0, 1'b0, t1, t2, m, ONE, r);
      check_mant("div by one rule", m, r.mant);
      check_te("div by one rule", t1 - t2, r.te);
    end

    send("equal mant", 1'b0, 1'b0, exponent_t'(3), exponent_t'(1), ONE, ONE, r);
    for (int i = 0; i < 3; i++) begin
      m = rand_mant();
      send("equal mant", 1'b1, 1'b0, rand_te(), rand_te(), m, m, r);
    end

    for (int s = 0; s < 4; s++) begin
      sg = 2'(s);
      send("sign", sg[1], sg[0], rand_te(), rand_te(), rand_mant(), rand_mant(), r);
      check_bit("sign rule", (s == 1) || (s == 2), r.sign);   // negative only if signs differ
    end

    // 1.0 / 1.5 falls below one, so te takes the decrement too
    send("extreme te", 1'b0, 1'b1, exponent_t'(-TE_MAX), exponent_t'(TE_MAX),
         ONE, ONE_HALF, r);
    check_te("extreme te rule", exponent_t'(-2 * TE_MAX - 1), r.te);
    send("extreme te", 1'b1, 1'b0, exponent_t'(TE_MAX), exponent_t'(-TE_MAX),
         ONE_HALF, ONE, r);
    check_te("extreme te rule", exponent_t'(2 * TE_MAX), r.te);

    for (int i = 0; i < N_RANDOM; i++) begin
      send_random("random");                          // valid_i high every cycle
    end

    for (int i = 0; i < N_GAP; i++) begin
      if (rand_bit()) begin
        send_random("valid gaps");
      end else begin
        idle();
      end
    end
    idle();

    repeat (LAT) @(negedge clk_i);                    // the last result is due by now
    repeat (LAT) @(negedge clk_i);                    // no stray valid_o after the last one

    if (exp_q.size() != 0) begin
      $display("results still pending at the end of the run");
      end_with_failure();
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // scoreboard and timeout
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    vhist <= {vhist[LAT-2:0], valid_i};
  end

  // outputs are registered, so the falling edge sees them settled
  always @(negedge clk_i) begin : scoreboard
    result_t expected;
    string   tname;
    if (!rst) begin
      check_bit("valid pattern", vhist[LAT-1], valid_o);
      if (valid_o) begin
        if (exp_q.size() == 0) begin
          $display("valid_o went high with no operand pair pending");
          end_with_failure();
        end else begin
          expected = exp_q.pop_front();
          tname    = name_q.pop_front();
          check_bit(tname, expected.sign, sign_o);
          check_te(tname, expected.te, te_o);
          check_mant(tname, expected.mant, mant_o);
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d results pending", cycles, exp_q.size());
      end_with_failure();
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
posit_pkg.sv
div_pkg.sv
div_op_if.sv
pipe_delay.sv
recip_seed.sv
newton_raphson.sv
recip_path.sv
operand_path.sv
div_normalize.sv
div_top.sv
div_props.sv
tb_div_top.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
LINT     = --lint-only -Wall --timing
TOP      = tb_div_top
FLIST    = vlog.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS_MSG = PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)
